// File: hdl/bus_pkg.sv
package bus_pkg;

    ////////////////////////////////////////
    // bus widths

    localparam int ADDR_W = 16;
    localparam int DATA_W = 8;

    ////////////////////////////////////////
    // transaction types

    // one bit, read is zero like the 6502 rw line inverted
    typedef enum logic
    {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_t;

    // host command, 25 bits
    typedef struct packed
    {
        bus_op_t             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } bus_cmd_t;

    // response, data is read value or echo of the write
    typedef struct packed
    {
        bus_op_t             op;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   data;
    } bus_rsp_t;

    ////////////////////////////////////////
    // address map

    // ram 0000-1fff
    localparam logic [ADDR_W-1:0] RAM_TOP       = 16'h1FFF;
    // keyboard / display port d010-d013
    localparam logic [ADDR_W-1:0] IO_BASE       = 16'hD010;
    // nothing decoded
    localparam logic [DATA_W-1:0] UNMAPPED_DATA = 8'hFF;

    // port register offsets
    localparam logic [1:0] IO_KBD   = 2'd0;
    localparam logic [1:0] IO_KBDCR = 2'd1;
    localparam logic [1:0] IO_DSP   = 2'd2;
    localparam logic [1:0] IO_DSPCR = 2'd3;

endpackage

// File: hdl/sys_pkg.sv
package sys_pkg;

    ////////////////////////////////////////
    // timing

    // one cpu tick every 25 clk25 cycles
    localparam int CLKEN_DIV   = 25;
    localparam int CLKEN_W     = $clog2(CLKEN_DIV);

    // ticks of held reset after release
    localparam int RESET_TICKS = 8;
    localparam int TICK_W      = $clog2(RESET_TICKS + 1);

    ////////////////////////////////////////
    // sizing

    // queue depth and initial host credits
    localparam int CMD_CREDITS = 4;
    localparam int QPTR_W      = $clog2(CMD_CREDITS);
    localparam int QCNT_W      = $clog2(CMD_CREDITS + 1);

    // 4 x 2k banks cover 0000-1fff
    localparam int RAM_BANKS   = 4;
    localparam int BANK_AW     = 11;
    localparam int BANK_SEL_W  = $clog2(RAM_BANKS);

endpackage

// File: hdl/clock_reset_gen.sv
`timescale 1ns/10ps

module clock_reset_gen (
    input  logic clk25,
    input  logic pwr_up_reset,
    output logic cpu_clken,
    output logic sys_ready
);
    import sys_pkg::*;

    ////////////////////////////////////////
    // clock enable

    logic [CLKEN_W-1:0] clk_div;

    // wraps at div-1, enable pulses on count zero
    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            clk_div   <= '0;
            cpu_clken <= 1'b0;
        end
        else
        begin
            if (clk_div == CLKEN_W'(CLKEN_DIV - 1))
                clk_div <= '0;
            else
                clk_div <= clk_div + 1'b1;
            cpu_clken <= (clk_div == '0);
        end
    end

    ////////////////////////////////////////
    // power-up reset sequencer

    logic [TICK_W-1:0] tick_cnt;

    // count enable ticks, stop at the limit
    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            tick_cnt  <= '0;
            sys_ready <= 1'b0;
        end
        else if (cpu_clken && (tick_cnt != TICK_W'(RESET_TICKS)))
        begin
            tick_cnt <= tick_cnt + 1'b1;
            // last held tick, ready on the next cycle
            if (tick_cnt == TICK_W'(RESET_TICKS - 1))
                sys_ready <= 1'b1;
        end
    end

endmodule

// File: hdl/host_bus_master.sv
`timescale 1ns/10ps

module host_bus_master (
    input  logic                          clk25,
    input  logic                          pwr_up_reset,
    input  logic                          cpu_clken,
    input  logic                          sys_ready,
    input  logic                          cmd_valid,
    input  bus_pkg::bus_cmd_t             cmd,
    output logic [sys_pkg::RAM_BANKS-1:0] bank_sel,
    output logic                          io_sel,
    output logic                          bus_we,
    output logic [15:0]                   bus_addr,
    output logic [7:0]                    bus_wdata,
    output logic                          issue_valid,
    output bus_pkg::bus_cmd_t             issue_cmd
);
    import bus_pkg::*;
    import sys_pkg::*;

    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_ACCESS,
        ST_RETIRE
    } master_state_t;

    ////////////////////////////////////////
    // command queue

    bus_cmd_t          q_mem [CMD_CREDITS];
    logic [QPTR_W-1:0] wr_ptr;
    logic [QPTR_W-1:0] rd_ptr;
    logic [QCNT_W-1:0] q_count;
    logic              q_push;
    logic              q_pop;
    logic              q_full;
    logic              q_empty;
    bus_cmd_t          q_head;

    master_state_t     state;

    // host owns credits, so no full check here
    assign q_push  = cmd_valid && sys_ready;
    assign q_full  = (q_count == QCNT_W'(CMD_CREDITS));
    assign q_empty = (q_count == '0);
    assign q_head  = q_mem[rd_ptr];
    // one pop per idle tick
    assign q_pop   = (state == ST_IDLE) && cpu_clken && !q_empty;

    // storage, no reset
    always_ff @(posedge clk25)
    begin
        if (q_push)
            q_mem[wr_ptr] <= cmd;
    end

    // pointers wrap on power-of-two depth
    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            q_count <= '0;
        end
        else
        begin
            if (q_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (q_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({q_push, q_pop})
                2'b10:   q_count <= q_count + 1'b1;
                2'b01:   q_count <= q_count - 1'b1;
                default: q_count <= q_count;
            endcase
        end
    end

    ////////////////////////////////////////
    // address decode of queue head

    logic                  ram_hit;
    logic                  io_hit;
    logic [BANK_SEL_W-1:0] bank_idx;

    assign ram_hit  = (q_head.addr <= RAM_TOP);
    assign io_hit   = (q_head.addr[15:2] == IO_BASE[15:2]);
    // bank from the bits above the bank address
    assign bank_idx = q_head.addr[BANK_AW +: BANK_SEL_W];

    ////////////////////////////////////////
    // bus cycle FSM

    // idle -> access for one cycle -> retire with issue pulse
    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            state       <= ST_IDLE;
            bank_sel    <= '0;
            io_sel      <= 1'b0;
            bus_we      <= 1'b0;
            issue_valid <= 1'b0;
        end
        else
        begin
            case (state)
                ST_IDLE:
                begin
                    issue_valid <= 1'b0;
                    if (q_pop)
                    begin
                        bank_sel <= ram_hit ? (RAM_BANKS'(1) << bank_idx) : '0;
                        io_sel   <= io_hit;
                        // unmapped writes dropped
                        bus_we   <= (q_head.op == OP_WRITE) && (ram_hit || io_hit);
                        state    <= ST_ACCESS;
                    end
                end
                ST_ACCESS:
                begin
                    // selects held for just this cycle
                    bank_sel    <= '0;
                    io_sel      <= 1'b0;
                    bus_we      <= 1'b0;
                    issue_valid <= 1'b1;
                    state       <= ST_RETIRE;
                end
                default:
                begin
                    issue_valid <= 1'b0;
                    state       <= ST_IDLE;
                end
            endcase
        end
    end

    // payload copies of the popped command
    always_ff @(posedge clk25)
    begin
        if (q_pop)
        begin
            bus_addr  <= q_head.addr;
            bus_wdata <= q_head.data;
            issue_cmd <= q_head;
        end
    end

endmodule

// File: hdl/ram_bank.sv
`timescale 1ns/10ps

module ram_bank (
    input  logic                        clk25,
    input  logic                        sel,
    input  logic                        we,
    input  logic [sys_pkg::BANK_AW-1:0] addr,
    input  logic [7:0]                  wdata,
    output logic [7:0]                  rdata
);
    import sys_pkg::*;

    ////////////////////////////////////////
    // 2k x 8 storage

    logic [7:0] mem [2**BANK_AW];

    // write only when this bank is picked
    always_ff @(posedge clk25)
    begin
        if (sel && we)
            mem[addr] <= wdata;
    end

    // read registered every cycle
    // old data on a same-cycle write
    always_ff @(posedge clk25)
    begin
        rdata <= mem[addr];
    end

endmodule

// File: hdl/io_port.sv
`timescale 1ns/10ps

module io_port (
    input  logic       clk25,
    input  logic       pwr_up_reset,
    input  logic       sel,
    input  logic       we,
    input  logic [1:0] addr,
    input  logic [7:0] wdata,
    output logic [7:0] rdata,
    output logic [7:0] led
);
    import bus_pkg::*;

    logic [7:0] kbd_data;
    logic       kbd_ready;
    logic [7:0] dsp_count;

    ////////////////////////////////////////
    // register writes

    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            kbd_data  <= '0;
            kbd_ready <= 1'b0;
            led       <= '0;
            dsp_count <= '0;
        end
        else if (sel)
        begin
            if (we && (addr == IO_KBD))
            begin
                kbd_data  <= wdata;
                kbd_ready <= 1'b1;
            end
            // reading the key acknowledges it
            else if (!we && (addr == IO_KBD))
                kbd_ready <= 1'b0;

            if (we && (addr == IO_DSP))
            begin
                led       <= wdata;
                // wraps at 256
                dsp_count <= dsp_count + 1'b1;
            end
        end
    end

    ////////////////////////////////////////
    // registered read mux

    always_ff @(posedge clk25)
    begin
        case (addr)
            IO_KBD:   rdata <= kbd_data;
            IO_KBDCR: rdata <= {kbd_ready, 7'b0};
            IO_DSP:   rdata <= led;
            IO_DSPCR: rdata <= dsp_count;
            default:  rdata <= UNMAPPED_DATA;
        endcase
    end

endmodule

// File: hdl/bus_response.sv
`timescale 1ns/10ps

module bus_response (
    input  logic                               clk25,
    input  logic                               pwr_up_reset,
    input  logic                               issue_valid,
    input  bus_pkg::bus_cmd_t                  issue_cmd,
    input  logic [sys_pkg::RAM_BANKS-1:0][7:0] bank_rdata,
    input  logic [7:0]                         io_rdata,
    output logic                               rsp_valid,
    output bus_pkg::bus_rsp_t                  rsp,
    output logic                               credit_return
);
    import bus_pkg::*;
    import sys_pkg::*;

    ////////////////////////////////////////
    // decode of the issued address

    logic                  ram_hit;
    logic                  io_hit;
    logic [BANK_SEL_W-1:0] bank_idx;
    logic [7:0]            rd_data;

    assign ram_hit  = (issue_cmd.addr <= RAM_TOP);
    assign io_hit   = (issue_cmd.addr[15:2] == IO_BASE[15:2]);
    assign bank_idx = issue_cmd.addr[BANK_AW +: BANK_SEL_W];

    // chip-selected source, ff when unmapped
    always_comb
    begin
        rd_data = UNMAPPED_DATA;
        if (ram_hit)
            rd_data = bank_rdata[bank_idx];
        else if (io_hit)
            rd_data = io_rdata;
    end

    ////////////////////////////////////////
    // response register

    // one credit back per response
    always_ff @(posedge clk25)
    begin
        if (!pwr_up_reset)
        begin
            rsp_valid     <= 1'b0;
            credit_return <= 1'b0;
        end
        else
        begin
            rsp_valid     <= issue_valid;
            credit_return <= issue_valid;
        end
    end

    // writes echo their own data
    always_ff @(posedge clk25)
    begin
        if (issue_valid)
        begin
            rsp.op   <= issue_cmd.op;
            rsp.addr <= issue_cmd.addr;
            rsp.data <= (issue_cmd.op == OP_WRITE) ? issue_cmd.data : rd_data;
        end
    end

endmodule

// File: hdl/apple1_top.sv
`timescale 1ns/10ps

module apple1_top (
    input  logic              clk25,
    input  logic              pwr_up_reset,
    input  logic              cmd_valid,
    input  bus_pkg::bus_cmd_t cmd,
    output logic              credit_return,
    output logic              rsp_valid,
    output bus_pkg::bus_rsp_t rsp,
    output logic              sys_ready,
    output logic [7:0]        led
);
    import bus_pkg::*;
    import sys_pkg::*;

    ////////////////////////////////////////
    // wires

    logic                      cpu_clken;
    logic [RAM_BANKS-1:0]      bank_sel;
    logic                      io_sel;
    logic                      bus_we;
    logic [15:0]               bus_addr;
    logic [7:0]                bus_wdata;
    logic                      issue_valid;
    bus_cmd_t                  issue_cmd;
    logic [RAM_BANKS-1:0][7:0] bank_rdata;
    logic [7:0]                io_rdata;

    ////////////////////////////////////////
    // clock enable and reset

    clock_reset_gen u_clock_reset_gen (
        .clk25        (clk25),
        .pwr_up_reset (pwr_up_reset),
        .cpu_clken    (cpu_clken),
        .sys_ready    (sys_ready)
    );

    // stands in for the cpu
    host_bus_master u_host_bus_master (
        .clk25        (clk25),
        .pwr_up_reset (pwr_up_reset),
        .cpu_clken    (cpu_clken),
        .sys_ready    (sys_ready),
        .cmd_valid    (cmd_valid),
        .cmd          (cmd),
        .bank_sel     (bank_sel),
        .io_sel       (io_sel),
        .bus_we       (bus_we),
        .bus_addr     (bus_addr),
        .bus_wdata    (bus_wdata),
        .issue_valid  (issue_valid),
        .issue_cmd    (issue_cmd)
    );

    ////////////////////////////////////////
    // ram, four banks

    for (genvar i = 0; i < RAM_BANKS; i++)
    begin : g_bank
        ram_bank u_ram_bank (
            .clk25 (clk25),
            .sel   (bank_sel[i]),
            .we    (bus_we),
            .addr  (bus_addr[BANK_AW-1:0]),
            .wdata (bus_wdata),
            .rdata (bank_rdata[i])
        );
    end

    // keyboard / display
    io_port u_io_port (
        .clk25        (clk25),
        .pwr_up_reset (pwr_up_reset),
        .sel          (io_sel),
        .we           (bus_we),
        .addr         (bus_addr[1:0]),
        .wdata        (bus_wdata),
        .rdata        (io_rdata),
        .led          (led)
    );

    // read data back to the host
    bus_response u_bus_response (
        .clk25         (clk25),
        .pwr_up_reset  (pwr_up_reset),
        .issue_valid   (issue_valid),
        .issue_cmd     (issue_cmd),
        .bank_rdata    (bank_rdata),
        .io_rdata      (io_rdata),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .credit_return (credit_return)
    );

endmodule

// File: tb/apple1_chk.sv
`timescale 1ns/10ps

module apple1_chk (
    input logic                          clk25,
    input logic                          pwr_up_reset,
    input logic                          cpu_clken,
    input logic                          q_push,
    input logic                          q_full,
    input logic [sys_pkg::RAM_BANKS-1:0] bank_sel
);
    // set by any failing property, polled by the testbench
    logic assert_fail = 1'b0;

    ////////////////////////////////////////
    // queue

    // host holds no credit when the queue is full
    a_no_push_full: assert property (@(posedge clk25) disable iff (!pwr_up_reset)
        !(q_push && q_full))
    else
    begin
        assert_fail = 1'b1;
        $error("command accepted while the queue is full");
    end

    ////////////////////////////////////////
    // clock enable and selects

    // single-cycle tick
    a_clken_pulse: assert property (@(posedge clk25) disable iff (!pwr_up_reset)
        cpu_clken |=> !cpu_clken)
    else
    begin
        assert_fail = 1'b1;
        $error("cpu_clken high on two consecutive cycles");
    end

    // one bank at most
    a_bank_onehot: assert property (@(posedge clk25) disable iff (!pwr_up_reset)
        $onehot0(bank_sel))
    else
    begin
        assert_fail = 1'b1;
        $error("more than one bank select active");
    end

endmodule

bind host_bus_master apple1_chk u_chk (
    .clk25        (clk25),
    .pwr_up_reset (pwr_up_reset),
    .cpu_clken    (cpu_clken),
    .q_push       (q_push),
    .q_full       (q_full),
    .bank_sel     (bank_sel)
);

// File: tb/apple1_tb.sv
`timescale 1ns/10ps

module apple1_tb;
    import bus_pkg::*;
    import sys_pkg::*;

    localparam int TIMEOUT_CYCLES = 2000;

    logic        clk25;
    logic        pwr_up_reset;
    logic        cmd_valid;
    bus_cmd_t    cmd;
    logic        credit_return;
    logic        rsp_valid;
    bus_rsp_t    rsp;
    logic        sys_ready;
    logic [7:0]  led;

    // host side bookkeeping
    int          credits;
    logic [31:0] rnd_state;
    bus_rsp_t    exp_q[$];
    string       name_q[$];

    apple1_top UUT (
        .clk25         (clk25),
        .pwr_up_reset  (pwr_up_reset),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .credit_return (credit_return),
        .rsp_valid     (rsp_valid),
        .rsp           (rsp),
        .sys_ready     (sys_ready),
        .led           (led)
    );

    // 100 ns period
    always #50 clk25 = ~clk25;

    ////////////////////////////////////////
    // helpers

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t exp_rsp, input bus_rsp_t act);
        if (act !== exp_rsp)
            abort_run($sformatf(
                "Mismatch %s: expected op=%0d addr=%h data=%h actual op=%0d addr=%h data=%h",
                name, exp_rsp.op, exp_rsp.addr, exp_rsp.data, act.op, act.addr, act.data));
    endtask

    task automatic check_led(input string name, input logic [7:0] exp_led, input logic [7:0] act);
        if (act !== exp_led)
            abort_run($sformatf("Mismatch %s: expected %h actual %h", name, exp_led, act));
    endtask

    // outputs sampled on the falling edge where they have settled
    task automatic sample_outputs();
        bus_rsp_t exp_rsp;
        string    name;
        if (UUT.u_host_bus_master.u_chk.assert_fail)
            abort_run("an assertion on the bus master failed");
        // one credit per response, in the same cycle
        if (credit_return !== rsp_valid)
            abort_run("credit_return and rsp_valid did not pulse together");
        if (credit_return === 1'b1)
            credits++;
        if (rsp_valid === 1'b1)
        begin
            if (exp_q.size() == 0)
                abort_run("response arrived with no command outstanding");
            exp_rsp = exp_q.pop_front();
            name    = name_q.pop_front();
            check_rsp(name, exp_rsp, rsp);
        end
    endtask

    // drive on the rising edge and sample on the falling one
    task automatic run_cycle(input logic valid, input bus_cmd_t c);
        @(posedge clk25);
        cmd_valid <= valid;
        cmd       <= c;
        @(negedge clk25);
        sample_outputs();
    endtask

    task automatic idle_gap();
        int n;
        rnd_state = xorshift32(rnd_state);
        n = int'(rnd_state % 32'd5);
        repeat (n) run_cycle(1'b0, '0);
    endtask

    // one command spends one credit
    task automatic send_cmd(input string name, input bus_cmd_t c, input bus_rsp_t exp_rsp);
        int waited;
        waited = 0;
        while (credits == 0)
        begin
            run_cycle(1'b0, '0);
            waited++;
            if (waited > TIMEOUT_CYCLES)
                abort_run("timeout waiting for a command credit");
        end
        credits--;
        exp_q.push_back(exp_rsp);
        name_q.push_back(name);
        run_cycle(1'b1, c);
    endtask

    task automatic drain_responses();
        int waited;
        waited = 0;
        while (exp_q.size() != 0)
        begin
            run_cycle(1'b0, '0);
            waited++;
            if (waited > TIMEOUT_CYCLES)
                abort_run("timeout waiting for outstanding responses");
        end
    endtask

    ////////////////////////////////////////
    // one line of the test file

    task automatic run_line(input string name, input string op, input logic [15:0] addr,
                            input logic [7:0] data, input logic [7:0] exp_data);
        bus_cmd_t c;
        bus_rsp_t exp_rsp;
        logic     is_burst;
        is_burst = (op == "brd") || (op == "bwr");
        if (op == "led")
        begin
            drain_responses();
            check_led(name, exp_data, led);
        end
        else if ((op == "rd") || (op == "wr") || is_burst)
        begin
            c.op         = ((op == "wr") || (op == "bwr")) ? OP_WRITE : OP_READ;
            c.addr       = addr;
            c.data       = data;
            exp_rsp.op   = c.op;
            exp_rsp.addr = addr;
            exp_rsp.data = exp_data;
            // bursts go back to back and singles wait for their response
            if (!is_burst)
                idle_gap();
            send_cmd(name, c, exp_rsp);
            if (!is_burst)
                drain_responses();
        end
        else
            abort_run($sformatf("unknown operation %s in test %s", op, name));
    endtask

    ////////////////////////////////////////
    // main sequence

    int          fd;
    int          n_read;
    int          fields;
    int          cycles;
    string       line;
    string       name_tok;
    string       op_tok;
    logic [15:0] addr_v;
    logic [7:0]  data_v;
    logic [7:0]  exp_v;

    initial
    begin
        clk25        = 1'b0;
        pwr_up_reset = 1'b0;
        cmd_valid    = 1'b0;
        cmd          = '0;
        credits      = 0;
        rnd_state    = 32'd51;

        // 16 cycles of reset
        repeat (16) @(posedge clk25);
        pwr_up_reset <= 1'b1;

        // nothing may come back before sys_ready
        cycles = 0;
        while (sys_ready !== 1'b1)
        begin
            @(negedge clk25);
            if ((rsp_valid !== 1'b0) || (credit_return !== 1'b0))
                abort_run("response or credit seen before sys_ready");
            cycles++;
            if (cycles > TIMEOUT_CYCLES)
                abort_run("timeout waiting for sys_ready");
        end
        credits = CMD_CREDITS;

        fd = $fopen("tb/apple1_tests.txt", "r");
        if (fd == 0)
            abort_run("cannot open tb/apple1_tests.txt");
        while (!$feof(fd))
        begin
            n_read = $fgets(line, fd);
            fields = 0;
            // comment and blank lines give fewer than five fields
            if (n_read != 0)
                fields = $sscanf(line, "%s %s %h %h %h",
                                 name_tok, op_tok, addr_v, data_v, exp_v);
            if (fields == 5)
                run_line(name_tok, op_tok, addr_v, data_v, exp_v);
        end
        $fclose(fd);

        drain_responses();
        $display("Verification passed");
        $finish;
    end

endmodule

// File: tb/apple1_tests.txt
# name op addr data expect, addr and the two data columns in hex
# op rd / wr single command, brd / bwr back-to-back burst, led compares the led output
reset_led   led  0000  00  00
bank0_wr    wr   0010  5a  5a
bank0_rd    rd   0010  00  5a
bank1_wr    wr   0812  a5  a5
bank1_rd    rd   0812  00  a5
bank2_wr    wr   1234  3c  3c
bank2_rd    rd   1234  00  3c
bank3_wr    wr   1fff  c3  c3
bank3_rd    rd   1fff  00  c3
low_wr      wr   0000  11  11
unmap_rd    rd   8000  00  ff
unmap_wr    wr   8000  77  77
unmap_rd2   rd   8000  00  ff
low_rd      rd   0000  00  11
dsp_wr1     wr   d012  81  81
led_1       led  0000  00  81
dsp_rd1     rd   d012  00  81
dsp_wr2     wr   d012  42  42
led_2       led  0000  00  42
dsp_cnt     rd   d013  00  02
kbd_wr      wr   d010  41  41
kbd_cr1     rd   d011  00  80
kbd_rd      rd   d010  00  41
kbd_cr2     rd   d011  00  00
burst_w0    bwr  0100  11  11
burst_w1    bwr  0900  22  22
burst_w2    bwr  1100  33  33
burst_w3    bwr  1900  44  44
mid_rd      rd   0100  00  11
burst_r1    brd  0900  00  22
burst_r2    brd  1100  00  33
burst_r3    brd  1900  00  44
burst_r0    brd  0010  00  5a

// File: tb.f
hdl/bus_pkg.sv
hdl/sys_pkg.sv
hdl/clock_reset_gen.sv
hdl/host_bus_master.sv
hdl/ram_bank.sv
hdl/io_port.sv
hdl/bus_response.sv
hdl/apple1_top.sv
tb/apple1_chk.sv
tb/apple1_tb.sv

// File: Makefile
TOP := apple1_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f tb.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f tb.f --top-module $(TOP) -o $(TOP)_sim
	@out=$$(./obj_dir/$(TOP)_sim +verilator+error+limit+100 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "Verification passed"

clean:
	rm -rf obj_dir
